// File: logic/printer_pkg.sv
package printer_pkg;

    // ==================================================================
    // Message geometry
    // ==================================================================
    localparam int MSG_CHARS  = 8;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_COUNT = 2;

    // One printable character
    typedef logic [7:0] char_t;

    // Character 0 sits in the top byte and prints first
    typedef char_t [0:MSG_CHARS-1] msg_t;

    // ==================================================================
    // AXI4-Lite bus and UART register map
    // ==================================================================
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;

    typedef logic [AXI_ADDR_W-1:0] addr_t;
    typedef logic [AXI_DATA_W-1:0] data_t;

    localparam addr_t UART_TX_FIFO_ADDR = 32'd4;
    localparam addr_t UART_STATUS_ADDR  = 32'd8;

    // Status bit set while the UART TX FIFO is full
    localparam int TX_FULL_BIT = 3;

endpackage

// File: logic/printer_if.sv
`timescale 1ns/1ns

// Read side of one message FIFO
interface fifo_rd_if import printer_pkg::*; ();
    logic rd_en;
    logic valid;
    msg_t data;
    logic empty;

    // FIFO answers a read strobe one cycle later with valid and data
    modport fifo (input rd_en, output valid, output data, output empty);
    modport scanner (output rd_en, input valid, input data, input empty);
endinterface

// Command side of the AXI4-Lite master
interface bus_cmd_if import printer_pkg::*; ();
    // Write request and its idle level
    addr_t waddr;
    data_t wdata;
    logic  write;
    logic  widle;
    // Read request, returned data and idle level
    addr_t raddr;
    logic  read;
    data_t rdata;
    logic  ridle;

    modport user (output waddr, output wdata, output write, input widle,
                  output raddr, output read, input rdata, input ridle);
    modport master (input waddr, input wdata, input write, output widle,
                    input raddr, input read, output rdata, output ridle);
endinterface

// File: logic/msg_fifo.sv
`timescale 1ns/1ns

module msg_fifo import printer_pkg::*; (
    input  logic    CLK,
    input  logic    RESETN,
    input  msg_t    din,
    input  logic    wr_en,
    output logic    full,
    fifo_rd_if.fifo rd
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Circular buffer
    msg_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_wr;
    logic do_rd;

    // Writes while full are dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd.rd_en && !rd.empty;

    // Flags follow the registered occupancy
    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign rd.empty = (count == '0);

    // Storage and registered read port
    always_ff @(posedge CLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            rd.data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd.valid <= 1'b0;
        end else begin
            // Valid strobe one cycle after the read
            rd.valid <= do_rd;
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Scanner reads only a FIFO it has seen holding data
    a_no_read_empty: assert property (@(posedge CLK) disable iff (!RESETN)
        rd.rd_en |-> !rd.empty);

endmodule

// File: logic/fifo_scanner.sv
`timescale 1ns/1ns

module fifo_scanner import printer_pkg::*; (
    input  logic       CLK,
    input  logic       RESETN,
    fifo_rd_if.scanner rd_0,
    fifo_rd_if.scanner rd_1,
    output msg_t       msg,
    output logic       start,
    input  logic       printer_idle
);

    localparam int IDX_W = $clog2(FIFO_COUNT);

    typedef enum logic [1:0] {S_WAIT_IDLE, S_LOOK, S_READ} state_t;

    state_t           state;
    logic [IDX_W-1:0] fifo_idx;
    logic             cur_empty;
    logic             cur_valid;
    msg_t             cur_data;

    // FIFO picked by the round-robin index
    assign cur_empty = (fifo_idx == '0) ? rd_0.empty : rd_1.empty;
    assign cur_valid = (fifo_idx == '0) ? rd_0.valid : rd_1.valid;
    assign cur_data  = (fifo_idx == '0) ? rd_0.data  : rd_1.data;

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            state      <= S_WAIT_IDLE;
            fifo_idx   <= '0;
            start      <= 1'b0;
            rd_0.rd_en <= 1'b0;
            rd_1.rd_en <= 1'b0;
        end else begin
            // All strobes are single cycle
            start      <= 1'b0;
            rd_0.rd_en <= 1'b0;
            rd_1.rd_en <= 1'b0;
            case (state)
                S_WAIT_IDLE: begin
                    if (printer_idle) begin
                        state <= S_LOOK;
                    end
                end
                // Stay on a FIFO until it runs dry, then move on
                S_LOOK: begin
                    if (cur_empty) begin
                        fifo_idx <= (fifo_idx == IDX_W'(FIFO_COUNT - 1)) ? '0 : fifo_idx + 1'b1;
                    end else begin
                        rd_0.rd_en <= (fifo_idx == '0);
                        rd_1.rd_en <= (fifo_idx != '0);
                        state      <= S_READ;
                    end
                end
                S_READ: begin
                    if (cur_valid) begin
                        start <= 1'b1;
                        state <= S_WAIT_IDLE;
                    end
                end
                default: state <= S_WAIT_IDLE;
            endcase
        end
    end

    // Message payload handed to the printer
    always_ff @(posedge CLK) begin
        if (state == S_READ && cur_valid) begin
            msg <= cur_data;
        end
    end

    // Printer was idle in the cycle before every start
    a_start_when_idle: assert property (@(posedge CLK) disable iff (!RESETN)
        start |-> $past(printer_idle));

endmodule

// File: logic/char_printer.sv
`timescale 1ns/1ns

module char_printer import printer_pkg::*; (
    input  logic  CLK,
    input  logic  RESETN,
    input  msg_t  msg,
    input  logic  start,
    output logic  printer_idle,
    output char_t tx_char,
    output logic  tx_start,
    input  logic  tx_done
);

    localparam int IDX_W = $clog2(MSG_CHARS);

    typedef enum logic [1:0] {S_IDLE, S_SKIP, S_SEND, S_WAIT} state_t;

    state_t           state;
    msg_t             msg_q;
    logic [IDX_W-1:0] char_idx;
    logic             last_char;

    assign last_char    = (char_idx == IDX_W'(MSG_CHARS - 1));
    // Busy as soon as a start is pending
    assign printer_idle = (state == S_IDLE) && !start;

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            state    <= S_IDLE;
            char_idx <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        char_idx <= '0;
                        state    <= S_SKIP;
                    end
                end
                // Leading zeros, one per cycle
                S_SKIP: begin
                    if (msg_q[char_idx] != '0) begin
                        state <= S_SEND;
                    end else if (last_char) begin
                        state <= S_IDLE;
                    end else begin
                        char_idx <= char_idx + 1'b1;
                    end
                end
                S_SEND: begin
                    tx_start <= 1'b1;
                    state    <= S_WAIT;
                end
                // Inner zeros are sent like any other byte
                S_WAIT: begin
                    if (!tx_start && tx_done) begin
                        if (last_char) begin
                            state <= S_IDLE;
                        end else begin
                            char_idx <= char_idx + 1'b1;
                            state    <= S_SEND;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Local message copy and outgoing character
    always_ff @(posedge CLK) begin
        if (state == S_IDLE && start) begin
            msg_q <= msg;
        end
        if (state == S_SEND) begin
            tx_char <= msg_q[char_idx];
        end
    end

endmodule

// File: logic/uart_sender.sv
`timescale 1ns/1ns

module uart_sender import printer_pkg::*; (
    input  logic    CLK,
    input  logic    RESETN,
    input  char_t   tx_char,
    input  logic    tx_start,
    output logic    tx_done,
    bus_cmd_if.user bus
);

    typedef enum logic [1:0] {S_IDLE, S_POLL, S_CHECK, S_WRITE} state_t;

    state_t state;

    assign tx_done = (state == S_IDLE) && !tx_start;

    // Both register addresses are fixed
    assign bus.raddr = UART_STATUS_ADDR;
    assign bus.waddr = UART_TX_FIFO_ADDR;

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            state     <= S_IDLE;
            bus.read  <= 1'b0;
            bus.write <= 1'b0;
        end else begin
            bus.read  <= 1'b0;
            bus.write <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (tx_start) begin
                        state <= S_POLL;
                    end
                end
                S_POLL: begin
                    if (bus.ridle) begin
                        bus.read <= 1'b1;
                        state    <= S_CHECK;
                    end
                end
                // Poll again while the TX FIFO reports full
                S_CHECK: begin
                    if (bus.ridle) begin
                        if (bus.rdata[TX_FULL_BIT]) begin
                            bus.read <= 1'b1;
                        end else begin
                            state <= S_WRITE;
                        end
                    end
                end
                S_WRITE: begin
                    if (bus.widle) begin
                        bus.write <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Character zero-extended to a full bus word
    always_ff @(posedge CLK) begin
        if (state == S_WRITE && bus.widle) begin
            bus.wdata <= data_t'(tx_char);
        end
    end

endmodule

// File: logic/axil_master.sv
`timescale 1ns/1ns

module axil_master import printer_pkg::*; (
    input  logic      CLK,
    input  logic      RESETN,
    bus_cmd_if.master cmd,
    // Write address and data
    output addr_t     awaddr,
    output logic      awvalid,
    input  logic      awready,
    output data_t     wdata,
    output logic      wvalid,
    input  logic      wready,
    // Write response
    input  logic      bvalid,
    output logic      bready,
    // Read address and data
    output addr_t     araddr,
    output logic      arvalid,
    input  logic      arready,
    input  data_t     rdata,
    input  logic      rvalid,
    output logic      rready
);

    typedef enum logic [1:0] {W_IDLE, W_ADDR_DATA, W_RESP} wstate_t;
    typedef enum logic {R_IDLE, R_BUSY} rstate_t;

    wstate_t wstate;
    rstate_t rstate;
    logic    aw_seen;
    logic    w_seen;

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;
    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // Idle drops as soon as a request pulse arrives
    assign cmd.widle = (wstate == W_IDLE) && !cmd.write;
    assign cmd.ridle = (rstate == R_IDLE) && !cmd.read;

    // ==================================================================
    // Write machine
    // ==================================================================
    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            wstate  <= W_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
        end else begin
            case (wstate)
                W_IDLE: begin
                    if (cmd.write) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        aw_seen <= 1'b0;
                        w_seen  <= 1'b0;
                        wstate  <= W_ADDR_DATA;
                    end
                end
                // Address and data accepted in either order
                W_ADDR_DATA: begin
                    if (aw_hs) begin
                        awvalid <= 1'b0;
                        aw_seen <= 1'b1;
                    end
                    if (w_hs) begin
                        wvalid <= 1'b0;
                        w_seen <= 1'b1;
                    end
                    if ((aw_seen || aw_hs) && (w_seen || w_hs)) begin
                        bready <= 1'b1;
                        wstate <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (b_hs) begin
                        bready <= 1'b0;
                        wstate <= W_IDLE;
                    end
                end
                default: wstate <= W_IDLE;
            endcase
        end
    end

    // ==================================================================
    // Read machine
    // ==================================================================
    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            rstate  <= R_IDLE;
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else begin
            case (rstate)
                R_IDLE: begin
                    if (cmd.read) begin
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                        rstate  <= R_BUSY;
                    end
                end
                R_BUSY: begin
                    // Address drops at its own handshake
                    if (ar_hs) begin
                        arvalid <= 1'b0;
                    end
                    if (r_hs) begin
                        rready <= 1'b0;
                        rstate <= R_IDLE;
                    end
                end
                default: rstate <= R_IDLE;
            endcase
        end
    end

    // Address, data and returned word
    always_ff @(posedge CLK) begin
        if (wstate == W_IDLE && cmd.write) begin
            awaddr <= cmd.waddr;
            wdata  <= cmd.wdata;
        end
        if (rstate == R_IDLE && cmd.read) begin
            araddr <= cmd.raddr;
        end
        if (r_hs) begin
            cmd.rdata <= rdata;
        end
    end

    // No address is withdrawn before the slave takes it
    a_awvalid_hold: assert property (@(posedge CLK) disable iff (!RESETN)
        awvalid && !awready |=> awvalid);

endmodule

// File: logic/printer.sv
`timescale 1ns/1ns

module printer import printer_pkg::*; (
    input  logic  CLK,
    input  logic  RESETN,
    // Message inputs
    input  msg_t  fifo_0_in,
    input  logic  fifo_0_wr_en,
    output logic  fifo_0_full,
    input  msg_t  fifo_1_in,
    input  logic  fifo_1_wr_en,
    output logic  fifo_1_full,
    // AXI4-Lite master towards the UART
    output addr_t awaddr,
    output logic  awvalid,
    input  logic  awready,
    output data_t wdata,
    output logic  wvalid,
    input  logic  wready,
    input  logic  bvalid,
    output logic  bready,
    output addr_t araddr,
    output logic  arvalid,
    input  logic  arready,
    input  data_t rdata,
    input  logic  rvalid,
    output logic  rready
);

    fifo_rd_if rd_0_if ();
    fifo_rd_if rd_1_if ();
    bus_cmd_if bus_if ();

    // Scanner to printer
    msg_t  msg;
    logic  start;
    logic  printer_idle;
    // Printer to sender
    char_t tx_char;
    logic  tx_start;
    logic  tx_done;

    msg_fifo i_fifo_0 (.CLK(CLK), .RESETN(RESETN), .din(fifo_0_in), .wr_en(fifo_0_wr_en),
                       .full(fifo_0_full), .rd(rd_0_if));

    msg_fifo i_fifo_1 (.CLK(CLK), .RESETN(RESETN), .din(fifo_1_in), .wr_en(fifo_1_wr_en),
                       .full(fifo_1_full), .rd(rd_1_if));

    fifo_scanner i_scanner (.CLK(CLK), .RESETN(RESETN), .rd_0(rd_0_if), .rd_1(rd_1_if),
                            .msg(msg), .start(start), .printer_idle(printer_idle));

    char_printer i_char_printer (.CLK(CLK), .RESETN(RESETN), .msg(msg), .start(start),
                                 .printer_idle(printer_idle), .tx_char(tx_char),
                                 .tx_start(tx_start), .tx_done(tx_done));

    uart_sender i_uart_sender (.CLK(CLK), .RESETN(RESETN), .tx_char(tx_char),
                               .tx_start(tx_start), .tx_done(tx_done), .bus(bus_if));

    axil_master i_axil_master (
        .CLK(CLK), .RESETN(RESETN), .cmd(bus_if),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready)
    );

endmodule

// File: sim/uart_model.sv
`timescale 1ns/1ns

module uart_model import printer_pkg::*; (
    input  logic  CLK,
    input  logic  RESETN,
    // Write address and data
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready = 1'b0,
    input  data_t wdata,
    input  logic  wvalid,
    output logic  wready = 1'b0,
    output logic  bvalid = 1'b0,
    input  logic  bready,
    // Read address and data
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready = 1'b0,
    output data_t rdata = '0,
    output logic  rvalid = 1'b0,
    input  logic  rready,
    // Forces the TX FIFO full bit
    input  logic  stall,
    // One strobe per byte taken by the TX FIFO
    output logic  tx_valid = 1'b0,
    output char_t tx_byte = '0,
    output logic  bad_write = 1'b0
);

    logic        aw_got;
    logic        w_got;
    addr_t       addr_q;
    data_t       data_q;
    logic [31:0] rng;
    // Acceptance order of the next write
    // 0 address first, 1 data first, 2 both together
    logic [1:0]  order;

    // xorshift32 step
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Status word, full bit only
    function automatic data_t status_word(input logic tx_full);
        data_t w;
        w = '0;
        w[TX_FULL_BIT] = tx_full;
        return w;
    endfunction

    // ==================================================================
    // Write channel: acceptance order rotates from one write to the next
    // ==================================================================
    always @(posedge CLK) begin
        if (!RESETN) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            order     <= 2'd0;
            tx_valid  <= 1'b0;
            bad_write <= 1'b0;
        end else begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            tx_valid <= 1'b0;
            // Address waits for data only in data-first order
            if (awvalid && !awready && !aw_got && (order != 2'd1 || w_got)) begin
                awready <= 1'b1;
            end
            // Data waits for address only in address-first order
            if (wvalid && !wready && !w_got && (order != 2'd0 || aw_got)) begin
                wready <= 1'b1;
            end
            if (awvalid && awready) begin
                aw_got <= 1'b1;
                addr_q <= awaddr;
            end
            if (wvalid && wready) begin
                w_got  <= 1'b1;
                data_q <= wdata;
            end
            // Both halves in, so the byte lands in the TX FIFO
            if (aw_got && w_got && !bvalid) begin
                bvalid <= 1'b1;
                if (addr_q == UART_TX_FIFO_ADDR) begin
                    tx_valid <= 1'b1;
                    tx_byte  <= data_q[7:0];
                end else begin
                    bad_write <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                order  <= (order == 2'd2) ? 2'd0 : order + 1'b1;
            end
        end
    end

    // ==================================================================
    // Read channel: status register with a random full bit
    // ==================================================================
    always @(posedge CLK) begin
        if (!RESETN) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rng     <= 32'hb940;
        end else begin
            arready <= 1'b0;
            if (arvalid && !arready && !rvalid) begin
                arready <= 1'b1;
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                rng    <= xorshift(rng);
                // Full on about one read in four, always while stalled
                if (araddr == UART_STATUS_ADDR) begin
                    rdata <= status_word(stall || (rng[1:0] == 2'b00));
                end else begin
                    rdata <= '0;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

// File: sim/tb_printer.sv
`timescale 1ns/1ns

module tb_printer import printer_pkg::*; ();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 8;
    localparam int N_STIM         = 16;
    localparam int IDX_W          = $clog2(MSG_CHARS);
    localparam int TIMEOUT_CYCLES = N_STIM * MSG_CHARS * 400 + 2000;

    // One table row: target FIFO, message, group and stall for the group
    typedef struct packed {
        logic       fifo;
        msg_t       msg;
        logic [3:0] group;
        logic       stall;
    } stim_t;

    logic  CLK;
    logic  RESETN;
    msg_t  fifo_0_in;
    logic  fifo_0_wr_en;
    logic  fifo_0_full;
    msg_t  fifo_1_in;
    logic  fifo_1_wr_en;
    logic  fifo_1_full;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    data_t wdata;
    logic  wvalid;
    logic  wready;
    logic  bvalid;
    logic  bready;
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    data_t rdata;
    logic  rvalid;
    logic  rready;
    logic  stall;
    logic  tx_valid;
    char_t tx_byte;
    logic  bad_write;

    stim_t stim [N_STIM];
    // Every byte the UART took, in arrival order
    char_t log_q [$];

    printer i_printer (.*);

    uart_model i_uart_model (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // ==================================================================
    // Expected values and compare tasks
    // ==================================================================

    // Index of the first byte that prints, MSG_CHARS for an all-zero message
    function automatic int first_printed(input msg_t m);
        int c;
        c = 0;
        while (c < MSG_CHARS && m[c[IDX_W-1:0]] == 8'h00) begin
            c++;
        end
        return c;
    endfunction

    task automatic check_char(input char_t got, input char_t want, input int pos);
        if (got !== want) begin
            $display("ERROR at %0t ns: UART byte %0d is %02h, expected %02h",
                     $time, pos, got, want);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_full(input logic got, input logic want, input string name);
        if (got !== want) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, want);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // Byte log, sampled on the edge after the model's strobe
    always @(posedge CLK) begin
        if (tx_valid) begin
            log_q.push_back(tx_byte);
        end
    end

    always @(posedge CLK) begin
        if (bad_write) begin
            $display("The UART model saw a write to an address other than the TX FIFO");
            $display("Regression failed");
            $fatal(1);
        end
    end

    // Watchdog sized from the number of table characters
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("Timeout after %0d cycles, the UART never received all bytes",
                 TIMEOUT_CYCLES);
        $display("Regression failed");
        $fatal(1);
    end

    // ==================================================================
    // Stimulus
    // ==================================================================
    initial begin
        int         idx;
        int         base;
        int         total;
        int         i;
        int         c;
        int         n_wr [FIFO_COUNT];
        logic [3:0] grp;
        logic       grp_stall;
        logic       used_0;
        logic       used_1;
        logic       lead_1;
        char_t      want;
        char_t      exp_0 [$];
        char_t      exp_1 [$];

        RESETN       = 1'b0;
        fifo_0_in    = '0;
        fifo_0_wr_en = 1'b0;
        fifo_1_in    = '0;
        fifo_1_wr_en = 1'b0;
        stall        = 1'b0;

        stim = '{
            // Leading zeros stripped, inner and trailing zeros kept
            '{1'b0, 64'h0000_4869_0021_0a00, 4'd0, 1'b0},
            // All-zero message, then a full one
            '{1'b0, 64'h0000_0000_0000_0000, 4'd1, 1'b0},
            '{1'b0, 64'h4f4b_0000_0000_0d0a, 4'd1, 1'b0},
            // Both FIFOs in the same cycles
            '{1'b0, 64'h0000_0000_0000_4131, 4'd2, 1'b0},
            '{1'b1, 64'h0000_0000_0042_3132, 4'd2, 1'b0},
            '{1'b0, 64'h0000_0000_0000_4132, 4'd2, 1'b0},
            '{1'b1, 64'h0000_0000_0042_3232, 4'd2, 1'b0},
            // UART stalled, FIFO 1 overfilled, last write lost
            '{1'b1, 64'h0000_0000_0000_5331, 4'd3, 1'b1},
            '{1'b1, 64'h0000_0000_0000_5332, 4'd3, 1'b1},
            '{1'b1, 64'h0000_0000_0000_5333, 4'd3, 1'b1},
            '{1'b1, 64'h0000_0000_0000_5334, 4'd3, 1'b1},
            '{1'b1, 64'h0000_0000_0000_5335, 4'd3, 1'b1},
            '{1'b1, 64'h0000_0000_0000_5336, 4'd3, 1'b1},
            // Mixed traffic under random status full
            '{1'b0, 64'h5261_6e64_6f6d_2121, 4'd4, 1'b0},
            '{1'b1, 64'h0000_0058_5900_5a00, 4'd4, 1'b0},
            '{1'b0, 64'h0000_0000_0000_0001, 4'd4, 1'b0}
        };

        repeat (RESET_CYCLES) @(posedge CLK);
        RESETN <= 1'b1;
        @(negedge CLK);
        check_full(fifo_0_full, 1'b0, "fifo_0_full after reset");
        check_full(fifo_1_full, 1'b0, "fifo_1_full after reset");

        idx   = 0;
        total = 0;
        while (idx < N_STIM) begin
            grp       = stim[idx].group;
            grp_stall = stim[idx].stall;
            n_wr[0]   = 0;
            n_wr[1]   = 0;
            exp_0.delete();
            exp_1.delete();
            @(posedge CLK);
            stall <= grp_stall;

            // One cycle per pass, at most one write per FIFO in it
            while (idx < N_STIM && stim[idx].group == grp) begin
                used_0 = 1'b0;
                used_1 = 1'b0;
                fifo_0_wr_en <= 1'b0;
                fifo_1_wr_en <= 1'b0;
                while (idx < N_STIM && stim[idx].group == grp
                       && !(stim[idx].fifo ? used_1 : used_0)) begin
                    if (stim[idx].fifo) begin
                        fifo_1_in    <= stim[idx].msg;
                        fifo_1_wr_en <= 1'b1;
                        used_1 = 1'b1;
                    end else begin
                        fifo_0_in    <= stim[idx].msg;
                        fifo_0_wr_en <= 1'b1;
                        used_0 = 1'b1;
                    end
                    n_wr[stim[idx].fifo]++;
                    // Stalled: one in the printer plus FIFO_DEPTH stored survive
                    if (!grp_stall || n_wr[stim[idx].fifo] <= FIFO_DEPTH + 1) begin
                        for (c = first_printed(stim[idx].msg); c < MSG_CHARS; c++) begin
                            if (stim[idx].fifo) begin
                                exp_1.push_back(stim[idx].msg[c[IDX_W-1:0]]);
                            end else begin
                                exp_0.push_back(stim[idx].msg[c[IDX_W-1:0]]);
                            end
                        end
                    end
                    idx++;
                end
                @(posedge CLK);
            end
            fifo_0_wr_en <= 1'b0;
            fifo_1_wr_en <= 1'b0;

            if (grp_stall) begin
                // Flags settle behind the last write
                repeat (4) @(posedge CLK);
                @(negedge CLK);
                check_full(fifo_0_full, n_wr[0] > FIFO_DEPTH, "fifo_0_full while stalled");
                check_full(fifo_1_full, n_wr[1] > FIFO_DEPTH, "fifo_1_full while stalled");
                @(posedge CLK);
                stall <= 1'b0;
            end

            base  = total;
            total = total + exp_0.size() + exp_1.size();
            while (log_q.size() < total) begin
                @(negedge CLK);
            end

            // Scan position at group start is not visible, first byte shows the lead FIFO
            lead_1 = (exp_0.size() == 0);
            if (exp_0.size() > 0 && exp_1.size() > 0) begin
                lead_1 = (log_q[base] != exp_0[0]);
            end
            for (i = 0; i < total - base; i++) begin
                if (lead_1) begin
                    if (i < exp_1.size()) begin
                        want = exp_1[i];
                    end else begin
                        want = exp_0[i - exp_1.size()];
                    end
                end else begin
                    if (i < exp_0.size()) begin
                        want = exp_0[i];
                    end else begin
                        want = exp_1[i - exp_0.size()];
                    end
                end
                check_char(log_q[base + i], want, base + i);
            end
            check_full(fifo_0_full, 1'b0, "fifo_0_full after group");
            check_full(fifo_1_full, 1'b0, "fifo_1_full after group");
        end

        // Quiet time to catch stray bytes
        repeat (200) @(posedge CLK);
        @(negedge CLK);
        if (log_q.size() != total) begin
            $display("The UART received %0d bytes where %0d were expected",
                     log_q.size(), total);
            $display("Regression failed");
            $fatal(1);
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: files.f
logic/printer_pkg.sv
logic/printer_if.sv
logic/msg_fifo.sv
logic/fifo_scanner.sv
logic/char_printer.sv
logic/uart_sender.sv
logic/axil_master.sv
logic/printer.sv
sim/uart_model.sv
sim/tb_printer.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_printer
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
